// ==== Bender.yml ====
package:
  name: ifq

sources:
  - ifq_pkg.sv
  - inst_fifo.sv
  - fetch_pc.sv
  - fetch_cfg.sv
  - ifq_top.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - tb_ifq.sv

// ==== fetch_cfg.sv ====
`timescale 1ns/100ps

module fetch_cfg
  import ifq_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            cfg_we,
  input  logic            cfg_addr,
  input  logic [xlen-1:0] cfg_wdata,
  output logic [xlen-1:0] cfg_rdata,
  output logic            fetch_en,
  output logic [xlen-1:0] boot_pc,
  output logic            start
);

  logic wr_ctrl;
  logic wr_boot;

  assign wr_ctrl = cfg_we && (cfg_addr == cfg_addr_ctrl);
  assign wr_boot = cfg_we && (cfg_addr == cfg_addr_boot);

  // ctrl register, bit 0 is the fetch enable
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fetch_en <= 1'b0;
    end else if (wr_ctrl) begin
      fetch_en <= cfg_wdata[0];
    end
  end

  // start pulse on the 0 to 1 enable write
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      start <= 1'b0;
    end else begin
      start <= wr_ctrl && cfg_wdata[0] && !fetch_en;
    end
  end

  // boot address
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      boot_pc <= reset_pc;
    end else if (wr_boot) begin
      boot_pc <= cfg_wdata;
    end
  end

  // readback
  assign cfg_rdata = (cfg_addr == cfg_addr_ctrl) ? {{(xlen-1){1'b0}}, fetch_en} : boot_pc;

  a_start_single: assert property (
    @(posedge clk) disable iff (!rstn)
    start |=> !start
  ) else $error("fetch_cfg: start held for two cycles");

endmodule

// ==== fetch_pc.sv ====
`timescale 1ns/100ps

module fetch_pc
  import ifq_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            fetch_en,
  input  logic [xlen-1:0] boot_pc,
  input  logic            start,
  input  logic            flush,
  input  logic [xlen-1:0] redirect_pc,
  input  logic            full,
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_data,
  output logic            push,
  output logic [xlen-1:0] push_inst,
  output logic [xlen-1:0] push_pc
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_step;

  assign pc_step = pc + xlen'(4);

  // no push in the start cycle, pc is still being loaded
  assign push = fetch_en && !full && !start && !flush;

  // memory answers in the same cycle
  assign imem_addr = pc;
  assign push_inst = imem_data;
  assign push_pc   = pc;

  // program counter
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc <= reset_pc;
    end else if (flush) begin
      // execute redirect wins over everything
      pc <= redirect_pc;
    end else if (start) begin
      pc <= boot_pc;
    end else if (push) begin
      pc <= pc_step;
    end
    // held while full or disabled
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rstn)
    pc[1:0] == 2'b00
  ) else $error("fetch_pc: pc not word aligned (%h)", pc);

endmodule

// ==== ifq.f ====
ifq_pkg.sv
inst_fifo.sv
fetch_pc.sv
fetch_cfg.sv
ifq_top.sv
tb_clkgen.sv
tb_ifq.sv

// ==== ifq_pkg.sv ====
package ifq_pkg;

  // instruction and pc width
  localparam int xlen = 32;

  // queue geometry, depth must stay a power of two
  localparam int ifq_depth     = 16;
  localparam int ifq_log_depth = 4;

  // pc after reset, also the boot pc reset value
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] inst_nop = 32'h0000_0013;

  // configuration register map
  localparam logic cfg_addr_ctrl = 1'b0;
  localparam logic cfg_addr_boot = 1'b1;

endpackage

// ==== ifq_top.sv ====
`timescale 1ns/100ps

module ifq_top
  import ifq_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  // configuration
  input  logic            cfg_we,
  input  logic            cfg_addr,
  input  logic [xlen-1:0] cfg_wdata,
  output logic [xlen-1:0] cfg_rdata,
  // instruction memory
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_data,
  // execute
  input  logic            flush,
  input  logic [xlen-1:0] redirect_pc,
  // decode
  input  logic            pop_en,
  output logic [xlen-1:0] inst,
  output logic [xlen-1:0] inst_pc,
  output logic            empty,
  output logic            nearly_empty,
  output logic            full,
  output logic            nearly_full
);

  // config to fetch
  logic            fetch_en;
  logic [xlen-1:0] boot_pc;
  logic            start;

  // fetch to queue
  logic            push;
  logic [xlen-1:0] push_inst;
  logic [xlen-1:0] push_pc;

  fetch_cfg u_cfg (
    .clk       (clk),
    .rstn      (rstn),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .fetch_en  (fetch_en),
    .boot_pc   (boot_pc),
    .start     (start)
  );

  fetch_pc u_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_en    (fetch_en),
    .boot_pc     (boot_pc),
    .start       (start),
    .flush       (flush),
    .redirect_pc (redirect_pc),
    .full        (full),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .push        (push),
    .push_inst   (push_inst),
    .push_pc     (push_pc)
  );

  inst_fifo u_queue (
    .clk          (clk),
    .rstn         (rstn),
    .flush        (flush),
    .push         (push),
    .push_inst    (push_inst),
    .push_pc      (push_pc),
    .pop_en       (pop_en),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .empty        (empty),
    .nearly_empty (nearly_empty),
    .full         (full),
    .nearly_full  (nearly_full)
  );

endmodule

// ==== inst_fifo.sv ====
`timescale 1ns/100ps

module inst_fifo
  import ifq_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            flush,
  input  logic            push,
  input  logic [xlen-1:0] push_inst,
  input  logic [xlen-1:0] push_pc,
  input  logic            pop_en,
  output logic [xlen-1:0] inst,
  output logic [xlen-1:0] inst_pc,
  output logic            empty,
  output logic            nearly_empty,
  output logic            full,
  output logic            nearly_full
);

  // storage, word and pc side by side
  logic [xlen-1:0] mem_inst [ifq_depth];
  logic [xlen-1:0] mem_pc   [ifq_depth];

  logic [ifq_log_depth-1:0] rd_ptr;
  logic [ifq_log_depth-1:0] wr_ptr;
  logic [ifq_log_depth:0]   count;

  logic push_ok;
  logic pop_ok;

  // pop is dropped on an empty queue
  assign push_ok = push && !full;
  assign pop_ok  = pop_en && !empty;

  // pointers
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // wraps on its own, depth is a power of two
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // push with pop, or neither
        default: count <= count;
      endcase
    end
  end

  // entry write
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_inst[wr_ptr] <= push_inst;
      mem_pc[wr_ptr]   <= push_pc;
    end
  end

  // flags from the count
  assign full         = (count == ifq_depth);
  assign nearly_full  = (count == ifq_depth - 1);
  assign empty        = (count == 0);
  assign nearly_empty = (count == 1);

  // head entry, decode sees a no-op when nothing is held
  assign inst    = empty ? inst_nop : mem_inst[rd_ptr];
  assign inst_pc = empty ? '0 : mem_pc[rd_ptr];

  // fetch must hold off while the queue is full
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rstn)
    push |-> !full
  ) else $error("inst_fifo: push while full");

  a_full_empty: assert property (
    @(posedge clk) disable iff (!rstn)
    !(full && empty)
  ) else $error("inst_fifo: full and empty together");

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  localparam int clk_period = 40;
  localparam int rst_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // release lands on a falling edge
  initial begin
    rstn = 1'b0;
    #(rst_cycles * clk_period);
    rstn = 1'b1;
  end

endmodule

// ==== tb_ifq.sv ====
`timescale 1ns/100ps

module tb_ifq
  import ifq_pkg::*;
();

  localparam int clk_period    = 40;
  localparam int rst_cycles    = 16;
  localparam int t1_cycles     = 30;
  localparam int t2_cycles     = 80;
  localparam int t3_cycles     = 260;
  localparam int t4_cycles     = 80;
  localparam int t5_cycles     = 60;
  localparam int margin_cycles = 100;
  localparam int total_cycles  = rst_cycles + t1_cycles + t2_cycles + t3_cycles
                                 + t4_cycles + t5_cycles + margin_cycles;

  localparam logic [31:0]     rand_seed = 32'h02c85927;
  localparam logic [xlen-1:0] mem_salt  = 32'h6b8f_2d35;
  localparam logic [xlen-1:0] boot_a    = 32'h0000_1000;
  localparam logic [xlen-1:0] boot_b    = 32'h0000_8000;

  logic            clk;
  logic            rstn;
  logic            cfg_we;
  logic            cfg_addr;
  logic [xlen-1:0] cfg_wdata;
  logic [xlen-1:0] cfg_rdata;
  logic [xlen-1:0] imem_addr;
  logic [xlen-1:0] imem_data;
  logic            flush;
  logic [xlen-1:0] redirect_pc;
  logic            pop_en;
  logic [xlen-1:0] inst;
  logic [xlen-1:0] inst_pc;
  logic            empty;
  logic            nearly_empty;
  logic            full;
  logic            nearly_full;

  int err_count;
  int check_count;
  int test_num;
  int err_mark;
  int pop_total;
  int model_count;
  int ne_cycles;
  int pops_before;
  int held_count;
  int wait_n;

  // scoreboard and config shadow
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] boot_shadow;
  logic            en_shadow;

  // port monitor state
  logic [xlen-1:0] last_addr;
  logic            last_flush;
  logic            last_pop;
  logic            mon_valid;
  logic [xlen-1:0] held_addr;

  tb_clkgen u_clkgen (
    .clk  (clk),
    .rstn (rstn)
  );

  ifq_top uut (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .flush        (flush),
    .redirect_pc  (redirect_pc),
    .pop_en       (pop_en),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .empty        (empty),
    .nearly_empty (nearly_empty),
    .full         (full),
    .nearly_full  (nearly_full)
  );

  // instruction memory, answers in the same cycle
  assign imem_data = {imem_addr[15:0], imem_addr[31:16]} ^ mem_salt;

  function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] pc);
    return {pc[15:0], pc[31:16]} ^ mem_salt;
  endfunction

  task automatic log_mismatch(input string msg);
    err_count++;
    $display("ERR %0d ns: %s", $time, msg);
  endtask

  task automatic log_failure(input string msg);
    err_count++;
    $display("%s", msg);
  endtask

  task automatic check_value(input string what, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] want);
    check_count++;
    assert (got === want) else log_mismatch($sformatf("%s is %h, expected %h", what, got, want));
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s finished with %0d errors", test_num, name, err_count - err_mark);
    test_num++;
    err_mark = err_count;
  endtask

  // one register write, returns on the falling edge after the write edge
  task automatic cfg_write(input logic addr, input logic [xlen-1:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // compare every accepted pop against the reference
  always @(posedge clk) begin
    if (!rstn) begin
      exp_pc      = reset_pc;
      boot_shadow = reset_pc;
      en_shadow   = 1'b0;
    end else begin
      if (flush) begin
        exp_pc = redirect_pc;
      end else if (pop_en && !empty) begin
        check_value("popped pc", inst_pc, exp_pc);
        check_value("popped word", inst, expected_word(exp_pc));
        exp_pc = exp_pc + 32'd4;
        pop_total++;
      end
      if (cfg_we && cfg_addr == cfg_addr_boot) begin
        boot_shadow = cfg_wdata;
      end
      // enable edge restarts the stream at the boot pc
      if (cfg_we && cfg_addr == cfg_addr_ctrl) begin
        if (cfg_wdata[0] && !en_shadow) begin
          exp_pc = boot_shadow;
        end
        en_shadow = cfg_wdata[0];
      end
    end
  end

  // occupancy from the ports, a push shows up as imem_addr stepping by 4
  always @(posedge clk) begin
    if (!rstn) begin
      model_count = 0;
      mon_valid   = 1'b0;
    end else begin
      if (mon_valid) begin
        if (last_flush) begin
          model_count = 0;
        end else begin
          if (imem_addr == last_addr + 32'd4) begin
            model_count++;
          end
          if (last_pop) begin
            model_count--;
          end
        end
        check_value("nearly_empty", nearly_empty, model_count == 1);
        check_value("empty", empty, model_count == 0);
        check_value("nearly_full", nearly_full, model_count == ifq_depth - 1);
        check_value("full", full, model_count == ifq_depth);
        if (nearly_empty) begin
          ne_cycles++;
        end
      end
      last_addr  = imem_addr;
      last_flush = flush;
      last_pop   = pop_en && !empty;
      mon_valid  = 1'b1;
    end
  end

  // budget is the sum of the test lengths plus a margin
  initial begin
    #(total_cycles * clk_period);
    $display("watchdog: run timed out after %0d cycles without finishing the tests",
             total_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    cfg_we      = 1'b0;
    cfg_addr    = cfg_addr_ctrl;
    cfg_wdata   = '0;
    flush       = 1'b0;
    redirect_pc = '0;
    pop_en      = 1'b0;
    err_count   = 0;
    check_count = 0;
    test_num    = 1;
    err_mark    = 0;
    pop_total   = 0;
    ne_cycles   = 0;
    void'($urandom(rand_seed));
    @(posedge rstn);
    @(negedge clk);

    // idle after reset
    repeat (8) begin
      @(negedge clk);
      check_value("empty while idle", empty, 1'b1);
      check_value("full while idle", full, 1'b0);
      check_value("inst while idle", inst, inst_nop);
      check_value("imem_addr while idle", imem_addr, reset_pc);
    end
    cfg_addr = cfg_addr_ctrl;
    @(negedge clk);
    check_value("ctrl readback", cfg_rdata, 32'd0);
    cfg_addr = cfg_addr_boot;
    @(negedge clk);
    check_value("boot readback", cfg_rdata, reset_pc);
    finish_test("reset state");

    // fill to full with no pops
    cfg_write(cfg_addr_boot, boot_a);
    check_value("boot readback after write", cfg_rdata, boot_a);
    cfg_write(cfg_addr_ctrl, 32'd1);
    wait_n = 0;
    while (!nearly_full && wait_n < 40) begin
      @(negedge clk);
      wait_n++;
    end
    if (!nearly_full) begin
      log_failure("queue never reached nearly_full while filling");
    end
    check_value("full beside nearly_full", full, 1'b0);
    @(negedge clk);
    check_value("full one push later", full, 1'b1);
    check_value("pc held after 16 pushes", imem_addr, boot_a + 32'd64);
    held_addr = imem_addr;
    repeat (4) begin
      @(negedge clk);
      check_value("full held", full, 1'b1);
      check_value("imem_addr held while full", imem_addr, held_addr);
    end
    cfg_write(cfg_addr_ctrl, 32'd0);
    pops_before = pop_total;
    pop_en = 1'b1;
    repeat (ifq_depth) @(negedge clk);
    pop_en = 1'b0;
    check_value("pops to drain", pop_total - pops_before, ifq_depth);
    check_value("empty after drain", empty, 1'b1);
    check_value("inst after drain", inst, inst_nop);
    check_value("next expected pc", exp_pc, boot_a + 32'd64);
    finish_test("fill and drain");

    // random pops, first window keeps a single entry
    cfg_write(cfg_addr_boot, boot_b);
    cfg_write(cfg_addr_ctrl, 32'd1);
    pops_before = pop_total;
    ne_cycles   = 0;
    pop_en = 1'b1;
    repeat (30) @(negedge clk);
    repeat (200) begin
      pop_en = $urandom % 2;
      @(negedge clk);
    end
    pop_en = 1'b0;
    if (pop_total - pops_before < 80) begin
      log_failure("too few entries were popped during the random stream");
    end
    if (ne_cycles == 0) begin
      log_failure("nearly_empty was never seen during the random stream");
    end
    finish_test("random pop stream");

    // flush to a random aligned target
    redirect_pc = $urandom & 32'hffff_fffc;
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_value("empty after flush", empty, 1'b1);
    check_value("inst after flush", inst, inst_nop);
    wait_n = 0;
    while (empty && wait_n < 8) begin
      @(negedge clk);
      wait_n++;
    end
    if (empty) begin
      log_failure("no entry arrived after the flush");
    end
    check_value("head pc after flush", inst_pc, redirect_pc);
    check_value("head word after flush", inst, expected_word(redirect_pc));
    repeat (40) begin
      pop_en = $urandom % 2;
      @(negedge clk);
    end
    pop_en = 1'b0;
    finish_test("flush and redirect");

    // disable, then drain what is left
    cfg_write(cfg_addr_ctrl, 32'd0);
    @(negedge clk);
    held_addr  = imem_addr;
    held_count = model_count;
    repeat (5) begin
      @(negedge clk);
      check_value("imem_addr with fetch off", imem_addr, held_addr);
      check_value("entries with fetch off", model_count, held_count);
    end
    pops_before = pop_total;
    pop_en = 1'b1;
    wait_n = 0;
    while (!empty && wait_n < ifq_depth + 4) begin
      @(negedge clk);
      wait_n++;
    end
    pop_en = 1'b0;
    if (!empty) begin
      log_failure("queue did not drain after fetch was disabled");
    end
    check_value("pops while draining", pop_total - pops_before, held_count);
    repeat (2) begin
      @(negedge clk);
      check_value("inst after final drain", inst, inst_nop);
      check_value("inst_pc after final drain", inst_pc, 32'd0);
    end
    finish_test("disable and drain");

    $display("%0d tests, %0d checks, %0d errors", test_num - 1, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
